// ==== fft_input_loader.sv ====
`timescale 1ns/10ps

module fft_input_loader (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             in_valid,
   input  fft_pkg::sample_t in_re,
   input  fft_pkg::sample_t in_im,
   fft_stream_if.src        dst
);
   import fft_pkg::*;

   point_addr_t cnt;       // natural order position
   point_addr_t rev_addr;

   // DIT wants the input in bit-reversed order
   assign rev_addr = {<<{cnt}};

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cnt       <= '0;
         dst.valid <= 1'b0;
      end else begin
         dst.valid <= in_valid;
         if (in_valid) begin
            cnt <= cnt + 1'b1;   // wraps every frame
         end
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid) begin
         dst.addr <= rev_addr;
         dst.re   <= in_re;
         dst.im   <= in_im;
      end
   end

endmodule

// ==== fft_macros.svh ====
`ifndef FFT_MACROS_SVH
`define FFT_MACROS_SVH

// transform size
`define FFT_N 32
`define FFT_LOG2N 5       // stage count and address width

// sample path
`define FFT_DW 18         // real or imaginary component width

// twiddle factors
`define FFT_TW_W 14       // signed cos and sin width
`define FFT_TW_FRAC 12    // fraction bits, 1.0 is 4096

`endif

// ==== fft_output_unloader.sv ====
`timescale 1ns/10ps
`include "fft_macros.svh"

module fft_output_unloader (
   input  logic                 clk,
   input  logic                 arst_n,
   fft_stream_if.dst            up,
   output logic                 out_valid,
   output fft_pkg::point_addr_t out_index,
   output fft_pkg::sample_t     out_re,
   output fft_pkg::sample_t     out_im
);
   import fft_pkg::*;

   sample_t     buf_re [2][`FFT_N];
   sample_t     buf_im [2][`FFT_N];
   point_addr_t wr_cnt, rd_cnt;
   logic        wr_bank, rd_bank, rd_active, frame_done;

   assign frame_done = up.valid && (wr_cnt == point_addr_t'(`FFT_N - 1));

   always_ff @(posedge clk) begin
      if (up.valid) begin
         buf_re[wr_bank][up.addr] <= up.re;   // scattered write by bin
         buf_im[wr_bank][up.addr] <= up.im;
      end
      out_index <= rd_cnt;
      out_re    <= buf_re[rd_bank][rd_cnt];
      out_im    <= buf_im[rd_bank][rd_cnt];
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_cnt    <= '0;
         wr_bank   <= 1'b0;
         rd_cnt    <= '0;
         rd_bank   <= 1'b0;
         rd_active <= 1'b0;
         out_valid <= 1'b0;
      end else begin
         out_valid <= rd_active;
         if (up.valid) wr_cnt <= wr_cnt + 1'b1;
         if (frame_done) begin
            wr_bank   <= ~wr_bank;
            rd_bank   <= wr_bank;    // drain the bank just filled
            rd_cnt    <= '0;
            rd_active <= 1'b1;
         end else if (rd_active) begin
            rd_cnt <= rd_cnt + 1'b1;
            if (&rd_cnt) rd_active <= 1'b0;
         end
      end
   end

endmodule

// ==== fft_pkg.sv ====
`include "fft_macros.svh"

package fft_pkg;

   // one real or imaginary component
   typedef logic signed [`FFT_DW-1:0] sample_t;

   // cos or sin in Q12
   typedef logic signed [`FFT_TW_W-1:0] twiddle_t;

   // position within a frame
   typedef logic [`FFT_LOG2N-1:0] point_addr_t;

   // twiddle rom index, W32^0 .. W32^15
   typedef logic [`FFT_LOG2N-2:0] tw_idx_t;

   // stage read sequencer
   typedef enum logic [1:0] {
      idle,
      read_a,
      read_b
   } stage_state_e;

endpackage

// ==== fft_stage.sv ====
`timescale 1ns/10ps
`include "fft_macros.svh"

module fft_stage #(
   parameter int STAGE = 0
) (
   input  logic      clk,
   input  logic      arst_n,
   fft_stream_if.dst up,
   fft_stream_if.src down
);
   import fft_pkg::*;

   localparam int HALF = 1 << STAGE;               // butterfly span
   localparam int PW   = `FFT_DW + `FFT_TW_W;      // product width
   localparam int SW   = `FFT_DW + 3;              // sum width

   point_addr_t           wr_cnt;
   logic                  wr_bank, rd_bank, frame_done;
   stage_state_e          state;
   logic [`FFT_LOG2N-2:0] pair;
   point_addr_t           addr_a, addr_b, rd_addr, a_addr_q, b_addr_q;
   tw_idx_t               tw_idx;
   logic                  rd_en, got_a, got_b, send_b;
   sample_t               rd_re, rd_im, a_re, a_im, hold_re, hold_im;
   twiddle_t              tw_cos, tw_sin;
   logic signed [PW-1:0]  p_rc, p_is, p_rs, p_ic;
   logic signed [SW-1:0]  t_re, t_im, s_re, s_im, d_re, d_im;

   assign frame_done = up.valid && (wr_cnt == point_addr_t'(`FFT_N - 1));
   assign addr_a = point_addr_t'((int'(pair) / HALF) * 2 * HALF + int'(pair) % HALF);
   assign addr_b = addr_a + point_addr_t'(HALF);
   assign tw_idx = tw_idx_t'((int'(pair) % HALF) << (`FFT_LOG2N - 1 - STAGE));
   assign rd_en   = (state != idle);
   assign rd_addr = (state == read_b) ? addr_b : addr_a;

   fft_stage_ram #(.BANKS(2)) ram_i (
      .clk, .wr_en(up.valid), .wr_bank, .wr_addr(up.addr), .wr_re(up.re), .wr_im(up.im),
      .rd_en, .rd_bank, .rd_addr, .tw_idx, .rd_re, .rd_im, .tw_cos, .tw_sin
   );

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_cnt <= '0;
         wr_bank <= 1'b0;
         state <= idle;
         pair <= '0;
         rd_bank <= 1'b0;
         got_a <= 1'b0;
         got_b <= 1'b0;
         send_b <= 1'b0;
         down.valid <= 1'b0;
      end else begin
         if (up.valid) wr_cnt <= wr_cnt + 1'b1;
         if (frame_done) begin
            wr_bank <= ~wr_bank;            // next frame fills the other bank
            rd_bank <= wr_bank;
            pair <= '0;
            state <= read_a;
         end else if (state == read_a) begin
            state <= read_b;
         end else if (state == read_b) begin
            pair <= pair + 1'b1;
            state <= (&pair) ? idle : read_a;
         end
         got_a <= (state == read_a);
         got_b <= (state == read_b);
         send_b <= got_b;
         down.valid <= got_b | send_b;
      end
   end

   // B times twiddle, each product truncated to Q0
   assign p_rc = rd_re * tw_cos;
   assign p_is = rd_im * tw_sin;
   assign p_rs = rd_re * tw_sin;
   assign p_ic = rd_im * tw_cos;
   assign t_re = SW'(p_rc >>> `FFT_TW_FRAC) - SW'(p_is >>> `FFT_TW_FRAC);
   assign t_im = SW'(p_rs >>> `FFT_TW_FRAC) + SW'(p_ic >>> `FFT_TW_FRAC);
   assign s_re = a_re + t_re;
   assign s_im = a_im + t_im;
   assign d_re = a_re - t_re;
   assign d_im = a_im - t_im;

   always_ff @(posedge clk) begin
      if (state == read_b) begin
         a_addr_q <= addr_a;
         b_addr_q <= addr_b;
      end
      if (got_a) begin
         a_re <= rd_re;
         a_im <= rd_im;
      end
      if (got_b) begin
         down.addr <= a_addr_q;
         down.re <= sample_t'(s_re >>> 1);   // halve each stage
         down.im <= sample_t'(s_im >>> 1);
         hold_re <= sample_t'(d_re >>> 1);
         hold_im <= sample_t'(d_im >>> 1);
      end else begin
         down.addr <= b_addr_q;              // B' one cycle after A'
         down.re <= hold_re;
         down.im <= hold_im;
      end
   end

endmodule

// ==== fft_stage_ram.sv ====
`timescale 1ns/10ps
`include "fft_macros.svh"

module fft_stage_ram #(
   parameter int BANKS = 2
) (
   input  logic                 clk,
   input  logic                 wr_en,
   input  logic                 wr_bank,
   input  fft_pkg::point_addr_t wr_addr,
   input  fft_pkg::sample_t     wr_re,
   input  fft_pkg::sample_t     wr_im,
   input  logic                 rd_en,
   input  logic                 rd_bank,
   input  fft_pkg::point_addr_t rd_addr,
   input  fft_pkg::tw_idx_t     tw_idx,
   output fft_pkg::sample_t     rd_re,
   output fft_pkg::sample_t     rd_im,
   output fft_pkg::twiddle_t    tw_cos,
   output fft_pkg::twiddle_t    tw_sin
);
   import fft_pkg::*;

   // round(4096*cos(pi*k/16)) and -round(4096*sin(pi*k/16))
   localparam twiddle_t COS_ROM [`FFT_N/2] = '{
      4096, 4017, 3784, 3406, 2896, 2276, 1567, 799,
      0, -799, -1567, -2276, -2896, -3406, -3784, -4017
   };
   localparam twiddle_t SIN_ROM [`FFT_N/2] = '{
      0, -799, -1567, -2276, -2896, -3406, -3784, -4017,
      -4096, -4017, -3784, -3406, -2896, -2276, -1567, -799
   };

   sample_t mem_re [BANKS][`FFT_N];
   sample_t mem_im [BANKS][`FFT_N];
   logic    wr_sel;
   logic    rd_sel;

   // a single-bank build ignores the bank select
   assign wr_sel = (BANKS > 1) ? wr_bank : 1'b0;
   assign rd_sel = (BANKS > 1) ? rd_bank : 1'b0;

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem_re[wr_sel][wr_addr] <= wr_re;
         mem_im[wr_sel][wr_addr] <= wr_im;
      end
   end

   // sample and twiddle come back together one cycle later
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_re  <= mem_re[rd_sel][rd_addr];
         rd_im  <= mem_im[rd_sel][rd_addr];
         tw_cos <= COS_ROM[tw_idx];
         tw_sin <= SIN_ROM[tw_idx];
      end
   end

endmodule

// ==== fft_stream_if.sv ====
`timescale 1ns/10ps

interface fft_stream_if;
   import fft_pkg::*;

   logic        valid;   // one sample per clock, no handshake
   point_addr_t addr;    // target slot in the next frame buffer
   sample_t     re;
   sample_t     im;

   modport src (
      output valid,
      output addr,
      output re,
      output im
   );

   modport dst (
      input valid,
      input addr,
      input re,
      input im
   );
endinterface

// ==== fft_top.sv ====
`timescale 1ns/10ps
`include "fft_macros.svh"

module fft_top (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 in_valid,
   input  fft_pkg::sample_t     in_re,
   input  fft_pkg::sample_t     in_im,
   output logic                 out_valid,
   output fft_pkg::point_addr_t out_index,
   output fft_pkg::sample_t     out_re,
   output fft_pkg::sample_t     out_im
);

   // link[s] feeds stage s, link[5] feeds the unloader
   fft_stream_if link [0:`FFT_LOG2N] ();

   fft_input_loader loader_i (
      .clk,
      .arst_n,
      .in_valid,
      .in_re,
      .in_im,
      .dst(link[0])
   );

   for (genvar s = 0; s < `FFT_LOG2N; s++) begin : g_stage
      fft_stage #(.STAGE(s)) stage_i (
         .clk,
         .arst_n,
         .up(link[s]),
         .down(link[s+1])
      );
   end

   fft_output_unloader unloader_i (
      .clk, .arst_n, .up(link[`FFT_LOG2N]),
      .out_valid, .out_index, .out_re, .out_im
   );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the FFT testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_fft -o tb_fft \
   > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
   cat "$BUILD_LOG"
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_fft > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Something failed" "$SIM_LOG"; then
   exit 1
fi

exit 0

// ==== src.f ====
+incdir+.
fft_pkg.sv
fft_stream_if.sv
fft_input_loader.sv
fft_stage_ram.sv
fft_stage.sv
fft_output_unloader.sv
fft_top.sv
tb_fft.sv

// ==== tb_fft.sv ====
`timescale 1ns/10ps
`include "fft_macros.svh"

module tb_fft;
   import fft_pkg::*;

   localparam real PI = 3.14159265358979;
   localparam int TIMEOUT = 2000;   // cycles to wait for a frame

   logic        clk;
   logic        arst_n;
   logic        in_valid;
   sample_t     in_re, in_im;
   logic        out_valid;
   point_addr_t out_index;
   sample_t     out_re, out_im;

   int seed = 32'h04c417fb;
   int tw_c [`FFT_N/2];
   int tw_s [`FFT_N/2];
   int frame_re [`FFT_N];
   int frame_im [`FFT_N];
   int exp_re_q [$];
   int exp_im_q [$];
   int checks, errors, tests, tests_failed;

   fft_top fft_top_i (
      .clk, .arst_n, .in_valid, .in_re, .in_im,
      .out_valid, .out_index, .out_re, .out_im
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic int round_real(input real x);
      if (x >= 0.0) return $rtoi(x + 0.5);
      return -$rtoi(0.5 - x);
   endfunction

   function automatic int wrap18(input int v);
      logic signed [17:0] t;
      t = v[17:0];                   // the datapath keeps 18 bits
      return int'(t);
   endfunction

   function automatic int bitrev5(input int n);
      int r;
      r = 0;
      for (int i = 0; i < 5; i++) begin
         if (n & (1 << i)) begin
            r |= 1 << (4 - i);
         end
      end
      return r;
   endfunction

   // bit-exact DIT transform of frame_re/frame_im onto the expected queues
   function automatic void queue_expected();
      int x_re [`FFT_N];
      int x_im [`FFT_N];
      int half, a, b, k, tr, ti, ar, ai;
      for (int n = 0; n < `FFT_N; n++) begin
         x_re[bitrev5(n)] = frame_re[n];
         x_im[bitrev5(n)] = frame_im[n];
      end
      for (int s = 0; s < `FFT_LOG2N; s++) begin
         half = 1 << s;
         for (int p = 0; p < `FFT_N/2; p++) begin
            a = (p / half) * 2 * half + p % half;
            b = a + half;
            k = (p % half) << (4 - s);
            tr = ((x_re[b] * tw_c[k]) >>> 12) - ((x_im[b] * tw_s[k]) >>> 12);
            ti = ((x_re[b] * tw_s[k]) >>> 12) + ((x_im[b] * tw_c[k]) >>> 12);
            ar = x_re[a];
            ai = x_im[a];
            x_re[a] = wrap18((ar + tr) >>> 1);
            x_im[a] = wrap18((ai + ti) >>> 1);
            x_re[b] = wrap18((ar - tr) >>> 1);
            x_im[b] = wrap18((ai - ti) >>> 1);
         end
      end
      for (int n = 0; n < `FFT_N; n++) begin
         exp_re_q.push_back(x_re[n]);
         exp_im_q.push_back(x_im[n]);
      end
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %s got %h expected %h", name, got, exp);
      end
   endtask

   // kind 0 impulse, 1 tone at bin 3, 2 random
   task automatic drive_frames(input int nframes, input int max_gap, input int kind);
      int gap;
      for (int f = 0; f < nframes; f++) begin
         for (int n = 0; n < `FFT_N; n++) begin
            frame_re[n] = (kind == 0) ? ((n == 0) ? 4096 : 0) :
                          (kind == 1) ? round_real(32768.0 * $cos(2.0 * PI * 3.0 * n / 32.0)) :
                          $random(seed) % 32768;
            frame_im[n] = (kind == 2) ? $random(seed) % 32768 : 0;
         end
         queue_expected();
         for (int n = 0; n < `FFT_N; n++) begin
            @(posedge clk);
            #2;
            in_valid = 1'b1;
            in_re = sample_t'(frame_re[n]);
            in_im = sample_t'(frame_im[n]);
         end
         gap = (max_gap > 0) ? 1 + (($random(seed) & 32'h7fffffff) % max_gap) : 0;
         for (int g = 0; g < gap; g++) begin
            @(posedge clk);
            #2 in_valid = 1'b0;
         end
      end
      @(posedge clk);
      #2 in_valid = 1'b0;
   endtask

   task automatic collect_frames(input int nframes);
      int wait_cnt;
      @(negedge clk);
      for (int f = 0; f < nframes; f++) begin
         wait_cnt = 0;
         while (out_valid !== 1'b1 && wait_cnt < TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
         end
         if (out_valid !== 1'b1) begin
            errors++;
            $display("frame %0d of this test never appeared at the output", f);
            return;
         end
         for (int i = 0; i < `FFT_N; i++) begin
            check_value("out_valid", 32'(out_valid), 32'd1);
            check_value("out_index", 32'(out_index), i);
            check_value($sformatf("out_re[%0d]", i), 32'(out_re), exp_re_q.pop_front());
            check_value($sformatf("out_im[%0d]", i), 32'(out_im), exp_im_q.pop_front());
            @(negedge clk);
         end
         if (f == nframes - 1) begin
            check_value("out_valid", 32'(out_valid), 32'd0);   // no 33rd cycle
         end
      end
   endtask

   task automatic run_test(input string name, input int nframes, input int max_gap,
                           input int kind);
      int errors_before;
      errors_before = errors;
      fork
         drive_frames(nframes, max_gap, kind);
         collect_frames(nframes);
      join
      exp_re_q.delete();             // nothing left over after a timeout
      exp_im_q.delete();
      tests++;
      if (errors != errors_before) tests_failed++;
      $display("%-14s %s, %0d errors", name, (errors == errors_before) ? "passed" : "FAILED",
               errors - errors_before);
   endtask

   initial begin
      arst_n = 1'b0;
      in_valid = 1'b0;
      in_re = '0;
      in_im = '0;
      for (int k = 0; k < `FFT_N/2; k++) begin
         tw_c[k] = round_real(4096.0 * $cos(PI * k / 16.0));
         tw_s[k] = -round_real(4096.0 * $sin(PI * k / 16.0));
      end
      repeat (2) @(posedge clk);
      #2 arst_n = 1'b1;

      tests = 1;
      for (int c = 0; c < 100; c++) begin
         @(negedge clk);
         check_value("out_valid", 32'(out_valid), 32'd0);
      end
      tests_failed = (errors != 0) ? 1 : 0;
      $display("%-14s %s, %0d errors", "reset_state", (errors == 0) ? "passed" : "FAILED", errors);

      run_test("impulse", 1, 0, 0);
      run_test("single_tone", 1, 0, 1);
      run_test("back_to_back", 8, 0, 2);
      run_test("with_gaps", 6, 20, 2);

      $display("%0d tests, %0d failed, %0d checks, %0d errors", tests, tests_failed,
               checks, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule
